/* build.f */
common/regfile_pkg.sv
regfile/regfile_array.sv
regfile/scan_write_thru.sv
source/obs_parity_flops.sv
source/regfile_top.sv
verification/regfile_tb.sv

/* common/regfile_pkg.sv */
// shared widths, port request structs and observation sizing for the two-read two-write register file

package regfile_pkg;

  // ----------------------------------------------------------------------
  // port widths
  // ----------------------------------------------------------------------

  // every port addresses the same array with the same word size
  localparam int addr_w = 5;
  localparam int data_w = 32;

  // ----------------------------------------------------------------------
  // port requests
  // ----------------------------------------------------------------------

  // one write port request, en sits in the top bit
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } wr_req_t;

  // one read port request, data comes back a cycle later
  typedef struct packed {
    logic              en;
    logic [addr_w-1:0] addr;
  } rd_req_t;

  // observed control bits are en and addr of two write and two read ports
  localparam int obs_pin_num = 4 * (1 + addr_w);

  // number of parity groups for a pin count and a group size
  // the division rounds up so the last group takes whatever is left over
  function automatic int obs_flop_num_f(input int pin_num, input int xor_size);
    return (pin_num + xor_size - 1) / xor_size;
  endfunction

endpackage

/* regfile/regfile_array.sv */
// storage array with two write ports and two registered read-old ports, instantiated by regfile_top
`timescale 1ns/10ps

module regfile_array
  import regfile_pkg::*;
#(
  parameter int ENTRIES = 24
)
(
  input  logic                   clock_b,
  input  logic                   rst,
  input  wr_req_t [1:0]          wr_req,
  input  rd_req_t [1:0]          rd_req,
  output logic [1:0][data_w-1:0] rd_data
);

  // ----------------------------------------------------------------------
  // elaboration checks
  // ----------------------------------------------------------------------

  // the address field must be able to reach every entry
  if (ENTRIES < 1 || ENTRIES > (1 << addr_w))
  begin : g_bad_entries
    $error("regfile_array: ENTRIES must lie between 1 and %0d", 1 << addr_w);
  end

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  logic [data_w-1:0] mem [ENTRIES];

  // both writes land on the same rising edge
  // port 1 is applied last in the loop so it wins a collision on one entry
  always_ff @(posedge clock_b)
  begin
    for (int k = 0; k < 2; k++)
    begin
      if (wr_req[k].en)
      begin
        mem[wr_req[k].addr] <= wr_req[k].data;
      end
    end
  end

  // ----------------------------------------------------------------------
  // read ports
  // ----------------------------------------------------------------------

  // reads sample mem before this edge's writes take effect (read-old)
  // a port with en low keeps its last word on the output
  always_ff @(posedge clock_b)
  begin
    if (rst)
    begin
      rd_data <= '0;
    end
    else
    begin
      for (int k = 0; k < 2; k++)
      begin
        if (rd_req[k].en)
        begin
          rd_data[k] <= mem[rd_req[k].addr];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------

  // an address past the last entry would silently drop a write
  // or return an undefined word on the next cycle
  for (genvar p = 0; p < 2; p++)
  begin : g_addr_chk
    a_wr_addr_range : assert property (
      @(posedge clock_b) disable iff (rst)
      wr_req[p].en |-> (int'(wr_req[p].addr) < ENTRIES)
    )
    else $error("regfile_array: write port %0d address 0x%0h out of range",
                p, wr_req[p].addr);

    // the read side matters one cycle later when the word reaches rd_data
    a_rd_addr_range : assert property (
      @(posedge clock_b) disable iff (rst)
      rd_req[p].en |-> (int'(rd_req[p].addr) < ENTRIES)
    )
    else $error("regfile_array: read port %0d address 0x%0h out of range",
                p, rd_req[p].addr);
  end

endmodule

/* regfile/scan_write_thru.sv */
// scan write-through path that blocks array writes in scan mode and returns write data on the read ports
`timescale 1ns/10ps

module scan_write_thru
  import regfile_pkg::*;
(
  input  logic                   clock_b,
  input  logic                   rst,
  input  logic                   scan_mode,
  input  wr_req_t [1:0]          wr_req,
  output wr_req_t [1:0]          array_wr,
  input  logic [1:0][data_w-1:0] array_rd_data,
  output logic [1:0][data_w-1:0] rd_data
);

  // scan_mode delayed to line up with the array read latency
  logic scan_q;

  // write data of each port captured on the scan edge
  logic [1:0][data_w-1:0] wt_data_q;

  // ----------------------------------------------------------------------
  // write side
  // ----------------------------------------------------------------------

  // address and data pass straight through, only the enable is masked
  always_comb
  begin
    for (int k = 0; k < 2; k++)
    begin
      array_wr[k]    = wr_req[k];
      array_wr[k].en = wr_req[k].en & ~scan_mode;
    end
  end

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------

  always_ff @(posedge clock_b)
  begin
    if (rst)
    begin
      scan_q <= 1'b0;
    end
    else
    begin
      scan_q <= scan_mode;
    end
  end

  // captured every cycle whatever the enables, the select decides use
  always_ff @(posedge clock_b)
  begin
    for (int k = 0; k < 2; k++)
    begin
      wt_data_q[k] <= wr_req[k].data;
    end
  end

  // one cycle after a scan edge each port shows its own write word
  // otherwise the array output goes through untouched
  always_comb
  begin
    for (int k = 0; k < 2; k++)
    begin
      rd_data[k] = scan_q ? wt_data_q[k] : array_rd_data[k];
    end
  end

  // ----------------------------------------------------------------------
  // assertions
  // ----------------------------------------------------------------------

  // nothing may reach the storage while the scan path is active
  a_no_write_in_scan : assert property (
    @(posedge clock_b) disable iff (rst)
    scan_mode |-> !(array_wr[0].en || array_wr[1].en)
  )
  else $error("scan_write_thru: array write enabled during scan mode");

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# compile the register file testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f build.f \
  --top-module regfile_tb \
  -o sim_regfile_tb \
  || { echo "verilator build failed"; exit 1; }

sim_out="$(./obj_dir/sim_regfile_tb 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "Testbench passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

/* source/obs_parity_flops.sv */
// parity compression of observed address and enable bits into flops sampled on the falling clock edge
`timescale 1ns/10ps

module obs_parity_flops
  import regfile_pkg::*;
#(
  parameter  int OBS_PIN_NUM  = obs_pin_num,
  parameter  int OBS_XOR_SIZE = 3,
  localparam int OBS_FLOP_NUM = obs_flop_num_f(OBS_PIN_NUM, OBS_XOR_SIZE)
)
(
  input  logic                    clock_b,
  input  logic                    rst,
  input  logic [OBS_PIN_NUM-1:0]  obs_in,
  output logic [OBS_FLOP_NUM-1:0] obs_out
);

  // a group of zero bits has no parity to take
  if (OBS_XOR_SIZE < 1)
  begin : g_bad_xor_size
    $error("obs_parity_flops: OBS_XOR_SIZE must be at least 1");
  end

  // one parity bit per group before capture
  logic [OBS_FLOP_NUM-1:0] grp_parity;

  // ----------------------------------------------------------------------
  // group parity
  // ----------------------------------------------------------------------

  // groups start at bit 0 and are OBS_XOR_SIZE wide
  // the top group is cut off at OBS_PIN_NUM and may come out narrower
  for (genvar g = 0; g < OBS_FLOP_NUM; g++)
  begin : g_group
    localparam int LO = g * OBS_XOR_SIZE;

    if (g < OBS_FLOP_NUM - 1)
    begin : g_full
      assign grp_parity[g] = ^obs_in[LO +: OBS_XOR_SIZE];
    end
    else
    begin : g_last
      assign grp_parity[g] = ^obs_in[OBS_PIN_NUM-1:LO];
    end
  end

  // ----------------------------------------------------------------------
  // observation flops
  // ----------------------------------------------------------------------

  // opposite phase to the array, the inputs driven after a rising edge
  // have settled by the following falling edge
  always_ff @(negedge clock_b)
  begin
    if (rst)
    begin
      obs_out <= '0;
    end
    else
    begin
      obs_out <= grp_parity;
    end
  end

endmodule

/* source/regfile_top.sv */
// top level of the register file subsystem, wiring array, scan write-through and observation flops
`timescale 1ns/10ps

module regfile_top
  import regfile_pkg::*;
#(
  parameter  int ENTRIES      = 24,
  parameter  int OBS_XOR_SIZE = 3,
  localparam int OBS_FLOP_NUM = obs_flop_num_f(obs_pin_num, OBS_XOR_SIZE)
)
(
  input  logic                    clock_b,
  input  logic                    rst,
  input  logic                    scan_mode,
  input  wr_req_t [1:0]           wr_req,
  input  rd_req_t [1:0]           rd_req,
  output logic [1:0][data_w-1:0]  rd_data,
  output logic [OBS_FLOP_NUM-1:0] obs_out
);

  // ----------------------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------------------

  // write requests after the scan mask
  wr_req_t [1:0] array_wr;

  // registered words straight from the storage
  logic [1:0][data_w-1:0] array_rd_data;

  // packed control bits for the observation logic
  logic [obs_pin_num-1:0] obs_vec;

  // ----------------------------------------------------------------------
  // observation vector
  // ----------------------------------------------------------------------

  // from bit 0 upward: wr0 en, wr0 addr, wr1 en, wr1 addr,
  // rd0 en, rd0 addr, rd1 en, rd1 addr
  // the pins are taken ahead of the scan mask so blocked writes still show
  assign obs_vec = {rd_req[1].addr, rd_req[1].en,
                    rd_req[0].addr, rd_req[0].en,
                    wr_req[1].addr, wr_req[1].en,
                    wr_req[0].addr, wr_req[0].en};

  // ----------------------------------------------------------------------
  // instances
  // ----------------------------------------------------------------------

  scan_write_thru u_scan_write_thru (
    .clock_b       (clock_b),
    .rst           (rst),
    .scan_mode     (scan_mode),
    .wr_req        (wr_req),
    .array_wr      (array_wr),
    .array_rd_data (array_rd_data),
    .rd_data       (rd_data)
  );

  regfile_array #(
    .ENTRIES (ENTRIES)
  ) u_regfile_array (
    .clock_b (clock_b),
    .rst     (rst),
    .wr_req  (array_wr),
    .rd_req  (rd_req),
    .rd_data (array_rd_data)
  );

  // flop count is derived inside from the same package function
  obs_parity_flops #(
    .OBS_PIN_NUM  (obs_pin_num),
    .OBS_XOR_SIZE (OBS_XOR_SIZE)
  ) u_obs_parity_flops (
    .clock_b (clock_b),
    .rst     (rst),
    .obs_in  (obs_vec),
    .obs_out (obs_out)
  );

endmodule

/* verification/regfile_tb.sv */
// self-checking testbench for regfile_top, directed phases and seeded random traffic against a model
`timescale 1ns/10ps

module regfile_tb
  import regfile_pkg::*;
();

  // ----------------------------------------------------------------------
  // configuration and run length
  // ----------------------------------------------------------------------

  localparam int ENTRIES        = 24;
  localparam int OBS_XOR_SIZE   = 3;
  localparam int OBS_FLOP_NUM   = obs_flop_num_f(obs_pin_num, OBS_XOR_SIZE);
  localparam int CLK_PERIOD     = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int FILL_CYCLES    = (ENTRIES + 1) / 2;
  localparam int COLLIDE_ROUNDS = 4;
  localparam int SCAN_CYCLES    = 8;
  localparam int RANDOM_CYCLES  = 500;

  // fill, read-old, verify and post-scan passes each take FILL_CYCLES
  localparam int PLANNED_CYCLES = RESET_CYCLES + 4 * FILL_CYCLES + 2 * COLLIDE_ROUNDS
                                  + SCAN_CYCLES + RANDOM_CYCLES + 8;
  localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

  logic                    clock_b;
  logic                    rst;
  logic                    scan_mode;
  wr_req_t [1:0]           wr_req;
  rd_req_t [1:0]           rd_req;
  logic [1:0][data_w-1:0]  rd_data;
  logic [OBS_FLOP_NUM-1:0] obs_out;

  // expected array contents, updated at each modelled rising edge
  logic [data_w-1:0] ref_mem [ENTRIES];

  logic [31:0] rng_state;
  int          cycle_count;

  regfile_top #(
    .ENTRIES      (ENTRIES),
    .OBS_XOR_SIZE (OBS_XOR_SIZE)
  ) dut_i (
    .clock_b   (clock_b),
    .rst       (rst),
    .scan_mode (scan_mode),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .rd_data   (rd_data),
    .obs_out   (obs_out)
  );

  initial
  begin
    clock_b = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2);
      clock_b = ~clock_b;
    end
  end

  // ----------------------------------------------------------------------
  // random numbers and reference functions
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // only addresses inside the array are ever driven
  function automatic logic [addr_w-1:0] rand_addr();
    return addr_w'(xorshift32() % ENTRIES);
  endfunction

  function automatic logic [data_w-1:0] ref_read(input logic [addr_w-1:0] addr);
    return ref_mem[addr];
  endfunction

  // one cycle after a scan edge the port shows its own write word
  function automatic logic [data_w-1:0] ref_rd_word(input logic              scan_q,
                                                    input logic [data_w-1:0] wt_word,
                                                    input logic [data_w-1:0] arr_word);
    return scan_q ? wt_word : arr_word;
  endfunction

  // control bits from bit 0: each write port's en then addr, then each read port's
  function automatic logic [obs_pin_num-1:0] pack_obs(input wr_req_t [1:0] wr,
                                                      input rd_req_t [1:0] rd);
    logic [obs_pin_num-1:0] v;
    int                     pos;
    v   = '0;
    pos = 0;
    for (int k = 0; k < 2; k++)
    begin
      v[pos]                = wr[k].en;
      v[pos + 1 +: addr_w]  = wr[k].addr;
      pos                   = pos + 1 + addr_w;
    end
    for (int k = 0; k < 2; k++)
    begin
      v[pos]                = rd[k].en;
      v[pos + 1 +: addr_w]  = rd[k].addr;
      pos                   = pos + 1 + addr_w;
    end
    return v;
  endfunction

  // bit b folds into group b / OBS_XOR_SIZE, so a short top group falls out by itself
  function automatic logic [OBS_FLOP_NUM-1:0] obs_groups(input logic [obs_pin_num-1:0] v);
    logic [OBS_FLOP_NUM-1:0] g;
    g = '0;
    for (int b = 0; b < obs_pin_num; b++)
    begin
      g[b / OBS_XOR_SIZE] = g[b / OBS_XOR_SIZE] ^ v[b];
    end
    return g;
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------

  task automatic check_rd_data(input int port, input logic [data_w-1:0] expected,
                               input logic [data_w-1:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] rd_data[%0d] expected 0x%h actual 0x%h at cycle %0d",
               port, expected, actual, cycle_count);
      $display("Testbench failed");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_obs(input logic [OBS_FLOP_NUM-1:0] expected,
                           input logic [OBS_FLOP_NUM-1:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] obs_out expected 0x%h actual 0x%h at cycle %0d",
               expected, actual, cycle_count);
      $display("Testbench failed");
      $fatal(1, "observation mismatch");
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus helpers, called right after a rising edge
  // ----------------------------------------------------------------------

  task automatic set_wr(input int port, input logic en, input logic [addr_w-1:0] addr,
                        input logic [data_w-1:0] data);
    wr_req_t w;
    w.en         = en;
    w.addr       = addr;
    w.data       = data;
    wr_req[port] <= w;
  endtask

  task automatic set_rd(input int port, input logic en, input logic [addr_w-1:0] addr);
    rd_req_t r;
    r.en         = en;
    r.addr       = addr;
    rd_req[port] <= r;
  endtask

  task automatic random_ports();
    logic [31:0]       r;
    logic [addr_w-1:0] wa;
    r  = xorshift32();
    wa = rand_addr();
    set_wr(0, r[0], wa, xorshift32());
    // about one cycle in eight both write ports hit one entry
    set_wr(1, r[1], (r[4:2] == 3'd0) ? wa : rand_addr(), xorshift32());
    set_rd(0, r[5], rand_addr());
    set_rd(1, r[6], rand_addr());
  endtask

  // reads every entry two at a time with writes off
  task automatic read_all();
    for (int e = 0; e < ENTRIES; e += 2)
    begin
      set_wr(0, 1'b0, '0, '0);
      set_wr(1, 1'b0, '0, '0);
      set_rd(0, 1'b1, addr_w'(e));
      set_rd(1, (e + 1 < ENTRIES), addr_w'(e + 1));
      @(posedge clock_b);
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial
  begin
    logic [addr_w-1:0] a;
    logic [31:0]       r;
    int                scan_left;
    rng_state = 32'd3145;
    rst       = 1'b1;
    scan_mode = 1'b0;
    wr_req    = '0;
    rd_req    = '0;
    scan_left = 0;
    repeat (RESET_CYCLES) @(posedge clock_b);
    rst <= 1'b0;

    // fill every entry, two per cycle
    for (int e = 0; e < ENTRIES; e += 2)
    begin
      set_wr(0, 1'b1, addr_w'(e), xorshift32());
      set_wr(1, (e + 1 < ENTRIES), addr_w'(e + 1), xorshift32());
      @(posedge clock_b);
    end

    // read each entry while overwriting it on the same edge, the old word must come back
    for (int e = 0; e < ENTRIES; e += 2)
    begin
      set_rd(0, 1'b1, addr_w'(e));
      set_rd(1, (e + 1 < ENTRIES), addr_w'(e + 1));
      set_wr(0, 1'b1, addr_w'(e), xorshift32());
      set_wr(1, (e + 1 < ENTRIES), addr_w'(e + 1), xorshift32());
      @(posedge clock_b);
    end
    read_all();

    // same address on both write ports, then read it back on both read ports
    for (int i = 0; i < COLLIDE_ROUNDS; i++)
    begin
      a = rand_addr();
      set_wr(0, 1'b1, a, xorshift32());
      set_wr(1, 1'b1, a, xorshift32());
      set_rd(0, 1'b0, '0);
      set_rd(1, 1'b0, '0);
      @(posedge clock_b);
      set_wr(0, 1'b0, '0, '0);
      set_wr(1, 1'b0, '0, '0);
      set_rd(0, 1'b1, a);
      set_rd(1, 1'b1, a);
      @(posedge clock_b);
    end

    // scan burst with random writes, then the whole array must be unchanged
    for (int i = 0; i < SCAN_CYCLES; i++)
    begin
      scan_mode <= 1'b1;
      random_ports();
      @(posedge clock_b);
    end
    scan_mode <= 1'b0;
    read_all();

    // mixed traffic with short scan bursts of one to four cycles
    for (int i = 0; i < RANDOM_CYCLES; i++)
    begin
      r = xorshift32();
      if (scan_left > 0)
      begin
        scan_left--;
      end
      else if (r[4:0] == 5'd0)
      begin
        scan_left = 1 + int'(r[6:5]);
      end
      scan_mode <= (scan_left > 0);
      random_ports();
      @(posedge clock_b);
    end

    scan_mode <= 1'b0;
    set_wr(0, 1'b0, '0, '0);
    set_wr(1, 1'b0, '0, '0);
    set_rd(0, 1'b0, '0);
    set_rd(1, 1'b0, '0);
    repeat (3) @(posedge clock_b);
    $display("Testbench passed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // model and compare, one pass per cycle just before the rising edge
  // ----------------------------------------------------------------------

  initial
  begin
    logic [1:0][data_w-1:0]  arr_rd;
    logic [1:0][data_w-1:0]  wt_data;
    logic                    scan_q;
    logic [OBS_FLOP_NUM-1:0] exp_obs;
    wr_req_t [1:0]           in_wr;
    rd_req_t [1:0]           in_rd;
    logic                    in_scan;
    logic                    in_rst;
    arr_rd  = '0;
    wt_data = '0;
    scan_q  = 1'b0;
    @(posedge clock_b);
    forever
    begin
      @(negedge clock_b);
      #(CLK_PERIOD / 2 - 1);
      // these inputs have been steady since the last rising edge
      in_wr   = wr_req;
      in_rd   = rd_req;
      in_scan = scan_mode;
      in_rst  = rst;

      // rd_data holds what the previous rising edge produced
      for (int k = 0; k < 2; k++)
      begin
        check_rd_data(k, ref_rd_word(scan_q, wt_data[k], arr_rd[k]), rd_data[k]);
      end

      // the falling edge just passed captured the inputs now applied
      exp_obs = in_rst ? '0 : obs_groups(pack_obs(in_wr, in_rd));
      check_obs(exp_obs, obs_out);

      // step the model over the coming edge, reads take the old contents first
      for (int k = 0; k < 2; k++)
      begin
        if (in_rst)
        begin
          arr_rd[k] = '0;
        end
        else if (in_rd[k].en)
        begin
          arr_rd[k] = ref_read(in_rd[k].addr);
        end
        wt_data[k] = in_wr[k].data;
      end
      scan_q = in_rst ? 1'b0 : in_scan;

      // port 1 is applied last so it wins a collision
      if (!in_scan)
      begin
        for (int k = 0; k < 2; k++)
        begin
          if (in_wr[k].en)
          begin
            ref_mem[in_wr[k].addr] = in_wr[k].data;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // watchdog
  // ----------------------------------------------------------------------

  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clock_b);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
        $display("timeout: run still going after %0d clock cycles", cycle_count);
        $display("Testbench failed");
        $fatal(1, "simulation timeout");
      end
    end
  end

endmodule
